// ==== src/video_pkg.sv ====
package video_pkg;

    // --------------------------------------------------
    // Camera pixel format
    // --------------------------------------------------

    // Gray level from the left tap
    localparam int pixel_w = 8;

    // Also used for the pupil threshold level
    typedef logic [pixel_w-1:0] pixel_t;

    // --------------------------------------------------
    // Frame geometry
    // --------------------------------------------------

    // Wide enough for 640 columns and 480 rows
    localparam int coord_w = 10;

    // Column or row number within a frame
    typedef logic [coord_w-1:0] coord_t;

endpackage

// ==== src/report_pkg.sv ====
package report_pkg;

    // --------------------------------------------------
    // Per-frame sums
    // --------------------------------------------------

    // Pixel count S
    localparam int sum_s_w = 20;

    // Coordinate sums SX and SY
    localparam int sum_xy_w = 28;

    typedef logic [sum_s_w-1:0]  sum_s_t;
    typedef logic [sum_xy_w-1:0] sum_xy_t;

    // --------------------------------------------------
    // Serial report layout
    // --------------------------------------------------

    typedef logic [7:0] byte_t;

    // Sync byte at the head of every report
    localparam byte_t report_header = 8'h5A;

    // Field sizes in bytes, each field LSB first
    localparam int s_bytes  = 3;
    localparam int xy_bytes = 4;

    // Header, S, SX, SY
    localparam int report_len = 1 + s_bytes + 2 * xy_bytes;

    typedef logic [3:0] report_idx_t;

endpackage

// ==== src/camera_input.sv ====
module camera_input (
    input  logic              cclk,
    input  logic              reset,
    input  logic              fval,
    input  logic              lval,
    input  logic              dval,
    input  video_pkg::pixel_t data,
    output logic              pix_valid,
    output video_pkg::pixel_t pix_data,
    output video_pkg::coord_t pix_x,
    output video_pkg::coord_t pix_y,
    output logic              frame_start,
    output logic              frame_done
);

    logic              fval_q;
    logic              lval_q;
    logic              in_valid;
    logic              line_end;
    video_pkg::coord_t col_cnt;
    video_pkg::coord_t row_cnt;

    // Pixel qualifies only with all three valids high
    assign in_valid = fval & lval & dval;
    assign line_end = lval_q & ~lval;

    // --------------------------------------------------
    // Edge history and frame pulses
    // --------------------------------------------------
    always_ff @(posedge cclk) begin
        if (reset) begin
            fval_q      <= 1'b0;
            lval_q      <= 1'b0;
            frame_start <= 1'b0;
            frame_done  <= 1'b0;
            pix_valid   <= 1'b0;
        end else begin
            fval_q      <= fval;
            lval_q      <= lval;
            frame_start <= fval & ~fval_q;
            frame_done  <= ~fval & fval_q;
            pix_valid   <= in_valid;
        end
    end

    // --------------------------------------------------
    // Position counters
    // --------------------------------------------------

    // Column advances on valid pixels only, so dval gaps are skipped
    always_ff @(posedge cclk) begin
        if (reset) begin
            col_cnt <= '0;
        end else if (!lval) begin
            col_cnt <= '0;
        end else if (in_valid) begin
            col_cnt <= col_cnt + 1'b1;
        end
    end

    // Row advances at the end of each line
    always_ff @(posedge cclk) begin
        if (reset) begin
            row_cnt <= '0;
        end else if (!fval) begin
            row_cnt <= '0;
        end else if (line_end) begin
            row_cnt <= row_cnt + 1'b1;
        end
    end

    // Pixel with the position it was received at
    always_ff @(posedge cclk) begin
        pix_data <= data;
        pix_x    <= col_cnt;
        pix_y    <= row_cnt;
    end

endmodule

// ==== src/pupil_accum.sv ====
module pupil_accum (
    input  logic                cclk,
    input  logic                reset,
    input  logic                pix_valid,
    input  logic                frame_start,
    input  logic                frame_done,
    input  video_pkg::pixel_t   pix_data,
    input  video_pkg::pixel_t   threshold,
    input  video_pkg::coord_t   pix_x,
    input  video_pkg::coord_t   pix_y,
    output report_pkg::sum_s_t  sum_s,
    output report_pkg::sum_xy_t sum_x,
    output report_pkg::sum_xy_t sum_y,
    output logic                sums_valid
);

    logic                dark;
    report_pkg::sum_s_t  run_s;
    report_pkg::sum_xy_t run_x;
    report_pkg::sum_xy_t run_y;
    report_pkg::sum_s_t  base_s;
    report_pkg::sum_xy_t base_x;
    report_pkg::sum_xy_t base_y;
    report_pkg::sum_s_t  add_s;
    report_pkg::sum_xy_t add_x;
    report_pkg::sum_xy_t add_y;

    // Pupil pixels are strictly darker than the threshold
    assign dark = pix_valid && (pix_data < threshold);

    // First pixel of a frame may arrive together with frame_start
    assign base_s = frame_start ? '0 : run_s;
    assign base_x = frame_start ? '0 : run_x;
    assign base_y = frame_start ? '0 : run_y;

    assign add_s = dark ? report_pkg::sum_s_t'(1) : '0;
    assign add_x = dark ? report_pkg::sum_xy_t'(pix_x) : '0;
    assign add_y = dark ? report_pkg::sum_xy_t'(pix_y) : '0;

    // --------------------------------------------------
    // Running sums over the current frame
    // --------------------------------------------------
    always_ff @(posedge cclk) begin
        if (reset) begin
            run_s <= '0;
            run_x <= '0;
            run_y <= '0;
        end else begin
            run_s <= base_s + add_s;
            run_x <= base_x + add_x;
            run_y <= base_y + add_y;
        end
    end

    // --------------------------------------------------
    // Frame result, held until the next frame ends
    // --------------------------------------------------
    always_ff @(posedge cclk) begin
        if (reset) begin
            sum_s      <= '0;
            sum_x      <= '0;
            sum_y      <= '0;
            sums_valid <= 1'b0;
        end else begin
            sums_valid <= frame_done;
            if (frame_done) begin
                sum_s <= run_s;
                sum_x <= run_x;
                sum_y <= run_y;
            end
        end
    end

endmodule

// ==== src/report_ctrl.sv ====
module report_ctrl (
    input  logic                cclk,
    input  logic                reset,
    input  logic                sums_valid,
    input  logic                tx_busy,
    input  report_pkg::sum_s_t  sum_s,
    input  report_pkg::sum_xy_t sum_x,
    input  report_pkg::sum_xy_t sum_y,
    output logic                tx_start,
    output report_pkg::byte_t   tx_data
);

    localparam int s_pad_w  = report_pkg::s_bytes * 8;
    localparam int xy_pad_w = report_pkg::xy_bytes * 8;
    localparam int msg_w    = report_pkg::report_len * 8;

    localparam report_pkg::report_idx_t last_idx =
        report_pkg::report_idx_t'(report_pkg::report_len - 1);

    typedef enum logic [1:0] {
        idle,
        send,
        wait_done
    } state_t;

    state_t                  state;
    report_pkg::report_idx_t idx;
    logic [s_pad_w-1:0]      s_pad;
    logic [xy_pad_w-1:0]     x_pad;
    logic [xy_pad_w-1:0]     y_pad;
    logic [msg_w-1:0]        msg_next;
    logic [msg_w-1:0]        msg;

    // --------------------------------------------------
    // Report image, byte 0 goes out first
    // --------------------------------------------------
    assign s_pad = s_pad_w'(sum_s);
    assign x_pad = xy_pad_w'(sum_x);
    assign y_pad = xy_pad_w'(sum_y);

    // Fields are LSB first, header in the lowest byte
    assign msg_next = {y_pad, x_pad, s_pad, report_pkg::report_header};

    // Captured once per report, so a new frame cannot disturb it
    always_ff @(posedge cclk) begin
        if (state == idle && sums_valid) begin
            msg <= msg_next;
        end
    end

    // --------------------------------------------------
    // Byte sequencer
    // --------------------------------------------------
    always_ff @(posedge cclk) begin
        if (reset) begin
            state <= idle;
            idx   <= '0;
        end else begin
            case (state)
                idle: begin
                    if (sums_valid) begin
                        idx   <= '0;
                        state <= send;
                    end
                end
                send: begin
                    // Transmitter raises busy on the next cycle
                    state <= wait_done;
                end
                wait_done: begin
                    if (!tx_busy) begin
                        if (idx == last_idx) begin
                            state <= idle;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= send;
                        end
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // One strobe per byte
    assign tx_start = (state == send);
    assign tx_data  = msg[int'(idx) * 8 +: 8];

endmodule

// ==== src/uart_tx.sv ====
module uart_tx #(
    parameter int clks_per_bit = 27
) (
    input  logic              cclk,
    input  logic              reset,
    input  logic              tx_start,
    input  report_pkg::byte_t tx_data,
    output logic              tx_busy,
    output logic              uart_txd
);

    localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

    // Bit 0 is the start bit, 1 to 8 data, 9 stop
    localparam int stop_bit = 9;

    logic [cnt_w-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    logic [8:0]       shreg;
    logic             bit_end;

    assign bit_end = (clk_cnt == cnt_w'(clks_per_bit - 1));

    // --------------------------------------------------
    // Bit timing and line driver
    // --------------------------------------------------
    always_ff @(posedge cclk) begin
        if (reset) begin
            tx_busy  <= 1'b0;
            uart_txd <= 1'b1;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy  <= 1'b1;
                uart_txd <= 1'b0;
                clk_cnt  <= '0;
                bit_cnt  <= '0;
            end
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'(stop_bit)) begin
                // Line is already high from the stop bit
                tx_busy <= 1'b0;
            end else begin
                uart_txd <= shreg[0];
                bit_cnt  <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // Data bits LSB first, then the stop bit
    always_ff @(posedge cclk) begin
        if (!tx_busy && tx_start) begin
            shreg <= {1'b1, tx_data};
        end else if (tx_busy && bit_end) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

endmodule

// ==== src/eye_tracker_top.sv ====
module eye_tracker_top #(
    parameter int clks_per_bit = 27
) (
    input  logic              cclk,
    input  logic              reset,
    input  logic              fval,
    input  logic              lval,
    input  logic              dval,
    input  video_pkg::pixel_t data,
    input  video_pkg::pixel_t threshold,
    output logic              uart_txd
);

    // Camera side
    logic                pix_valid;
    video_pkg::pixel_t   pix_data;
    video_pkg::coord_t   pix_x;
    video_pkg::coord_t   pix_y;
    logic                frame_start;
    logic                frame_done;

    // Frame sums
    report_pkg::sum_s_t  sum_s;
    report_pkg::sum_xy_t sum_x;
    report_pkg::sum_xy_t sum_y;
    logic                sums_valid;

    // Serial side
    logic                tx_start;
    report_pkg::byte_t   tx_data;
    logic                tx_busy;

    // --------------------------------------------------
    // Measurement path
    // --------------------------------------------------
    camera_input camera_input_i (
        .cclk        (cclk),
        .reset       (reset),
        .fval        (fval),
        .lval        (lval),
        .dval        (dval),
        .data        (data),
        .pix_valid   (pix_valid),
        .pix_data    (pix_data),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .frame_start (frame_start),
        .frame_done  (frame_done)
    );

    pupil_accum pupil_accum_i (
        .cclk        (cclk),
        .reset       (reset),
        .pix_valid   (pix_valid),
        .frame_start (frame_start),
        .frame_done  (frame_done),
        .pix_data    (pix_data),
        .threshold   (threshold),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .sum_s       (sum_s),
        .sum_x       (sum_x),
        .sum_y       (sum_y),
        .sums_valid  (sums_valid)
    );

    // --------------------------------------------------
    // Report output
    // --------------------------------------------------
    report_ctrl report_ctrl_i (
        .cclk       (cclk),
        .reset      (reset),
        .sums_valid (sums_valid),
        .tx_busy    (tx_busy),
        .sum_s      (sum_s),
        .sum_x      (sum_x),
        .sum_y      (sum_y),
        .tx_start   (tx_start),
        .tx_data    (tx_data)
    );

    uart_tx #(
        .clks_per_bit (clks_per_bit)
    ) uart_tx_i (
        .cclk     (cclk),
        .reset    (reset),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .uart_txd (uart_txd)
    );

endmodule

// ==== dv/eye_tracker_tb.sv ====
module eye_tracker_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_ns       = 40;
    localparam int clks_per_bit = 4;
    localparam int bit_ns       = clks_per_bit * clk_ns;
    localparam int report_bytes = 12;

    // Worst case per byte plus a few cycles of sequencing between bytes
    localparam int report_cycles = report_bytes * (10 * clks_per_bit + 4);

    localparam int mode_bright = 0;
    localparam int mode_dot    = 1;
    localparam int mode_rand   = 2;

    // --------------------------------------------------
    // Frame table
    // --------------------------------------------------
    // Entry 5 ends with a short gap, so entry 6 ends during its report
    localparam int num_tests = 8;
    localparam int frame_w [num_tests] = '{8, 12, 12, 16, 16, 20, 8, 10};
    localparam int frame_h [num_tests] = '{4, 6, 6, 8, 8, 10, 4, 5};
    localparam int thr_tbl [num_tests] = '{16, 128, 128, 64, 192, 255, 128, 96};
    localparam int mode_tbl [num_tests] = '{mode_bright, mode_dot, mode_dot, mode_rand,
                                            mode_rand, mode_rand, mode_rand, mode_rand};
    localparam int dot_col [num_tests] = '{0, 5, 11, 0, 0, 0, 0, 0};
    localparam int dot_row [num_tests] = '{0, 3, 5, 0, 0, 0, 0, 0};
    localparam int gap_tbl [num_tests] = '{700, 700, 700, 700, 700, 10, 700, 700};
    localparam int want_tbl [num_tests] = '{1, 1, 1, 1, 1, 1, 0, 1};

    logic              cclk;
    logic              reset;
    logic              fval;
    logic              lval;
    logic              dval;
    video_pkg::pixel_t data;
    video_pkg::pixel_t threshold;
    logic              uart_txd;

    int         seed;
    int         errors;
    int         failed;
    logic [7:0] exp_q[$];

    eye_tracker_top #(
        .clks_per_bit (clks_per_bit)
    ) eye_tracker_top_i (
        .cclk      (cclk),
        .reset     (reset),
        .fval      (fval),
        .lval      (lval),
        .dval      (dval),
        .data      (data),
        .threshold (threshold),
        .uart_txd  (uart_txd)
    );

    initial begin
        cclk = 1'b0;
        forever #(clk_ns / 2) cclk = ~cclk;
    end

    function automatic string mode_name(input int mode);
        if (mode == mode_dot) return "single dark pixel";
        if (mode == mode_rand) return "random pixels";
        return "all bright";
    endfunction

    function automatic int run_limit();
        int total;
        total = 20;
        for (int e = 0; e < num_tests; e++) begin
            total += 2 + frame_h[e] * (frame_w[e] + 4) + gap_tbl[e] + 2 * report_cycles;
        end
        return total + 1000;
    endfunction

    // Header, then S, SX and SY each LSB first
    task automatic push_report(input int s, input int sx, input int sy);
        logic [31:0] vs;
        logic [31:0] vx;
        logic [31:0] vy;
        vs = s;
        vx = sx;
        vy = sy;
        exp_q.push_back(8'h5A);
        for (int i = 0; i < 3; i++) exp_q.push_back(vs[8*i +: 8]);
        for (int i = 0; i < 4; i++) exp_q.push_back(vx[8*i +: 8]);
        for (int i = 0; i < 4; i++) exp_q.push_back(vy[8*i +: 8]);
    endtask

    // --------------------------------------------------
    // One frame with its reference sums
    // --------------------------------------------------
    task automatic drive_frame(input int e, output int s, output int sx, output int sy);
        int                rnd;
        video_pkg::pixel_t pix;
        s  = 0;
        sx = 0;
        sy = 0;
        @(negedge cclk);
        threshold = video_pkg::pixel_t'(thr_tbl[e]);
        fval = 1'b1;
        for (int row = 0; row < frame_h[e]; row++) begin
            for (int col = 0; col < frame_w[e]; col++) begin
                // Mid-line stall whose dark data must not count
                if (col == frame_w[e] / 2) begin
                    @(negedge cclk);
                    lval = 1'b1;
                    dval = 1'b0;
                    data = '0;
                end
                case (mode_tbl[e])
                    mode_dot: pix = (col == dot_col[e] && row == dot_row[e]) ? 8'h00 : 8'hF0;
                    mode_rand: begin
                        rnd = $random(seed);
                        pix = rnd[7:0];
                    end
                    default: pix = 8'hF0;
                endcase
                @(negedge cclk);
                lval = 1'b1;
                dval = 1'b1;
                data = pix;
                if (int'(pix) < thr_tbl[e]) begin
                    s  += 1;
                    sx += col;
                    sy += row;
                end
            end
            repeat (3) begin
                @(negedge cclk);
                lval = 1'b0;
                dval = 1'b0;
                data = '0;
            end
        end
        @(negedge cclk);
        fval = 1'b0;
    endtask

    // --------------------------------------------------
    // UART decoder sampling mid bit
    // --------------------------------------------------
    initial begin : uart_decoder
        logic [7:0] rx;
        logic [7:0] want;
        wait (reset == 1'b0);
        forever begin
            @(negedge uart_txd);
            #(bit_ns / 2);
            if (uart_txd !== 1'b0) begin
                $display("Start bit on uart_txd did not stay low at %0t", $time);
                errors++;
            end
            for (int i = 0; i < 8; i++) begin
                #(bit_ns);
                rx[i] = uart_txd;
            end
            #(bit_ns);
            if (uart_txd !== 1'b1) begin
                $display("Stop bit on uart_txd missing at %0t", $time);
                errors++;
            end
            if (exp_q.size() == 0) begin
                $display("Extra byte 0x%02h on uart_txd with no report expected", rx);
                errors++;
            end else begin
                want = exp_q.pop_front();
                if (rx !== want) begin
                    $display("ERR uart_txd byte: expected 0x%02h, got 0x%02h", want, rx);
                    errors++;
                end
            end
        end
    end

    initial begin : watchdog
        int limit;
        limit = run_limit();
        repeat (limit) @(posedge cclk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("FAIL: see errors above");
        $finish;
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin : main_seq
        int s;
        int sx;
        int sy;
        int errs_before;
        reset     = 1'b1;
        fval      = 1'b0;
        lval      = 1'b0;
        dval      = 1'b0;
        data      = '0;
        threshold = '0;
        seed      = 32'hc030;
        errors    = 0;
        failed    = 0;
        repeat (10) @(negedge cclk);
        reset = 1'b0;
        repeat (5) @(negedge cclk);
        if (uart_txd !== 1'b1) begin
            $display("ERR uart_txd: expected 0x1, got 0x%h", uart_txd);
            errors++;
        end

        for (int e = 0; e < num_tests; e++) begin
            errs_before = errors;
            drive_frame(e, s, sx, sy);
            if (want_tbl[e] != 0) begin
                push_report(s, sx, sy);
            end
            repeat (gap_tbl[e]) @(negedge cclk);
            // A long gap leaves time for the whole report
            if (gap_tbl[e] >= report_cycles && exp_q.size() != 0) begin
                $display("Report missing or incomplete after test %0d, %0d bytes not received",
                         e, exp_q.size());
                errors++;
                exp_q.delete();
            end
            if (errors == errs_before) begin
                $display("test %0d (%s, S=%0d SX=%0d SY=%0d): ok",
                         e, mode_name(mode_tbl[e]), s, sx, sy);
            end else begin
                failed++;
                $display("test %0d (%s): failed with %0d errors",
                         e, mode_name(mode_tbl[e]), errors - errs_before);
            end
        end

        $display("Summary: %0d tests, %0d failed, %0d errors", num_tests, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
src/video_pkg.sv
src/report_pkg.sv
src/camera_input.sv
src/pupil_accum.sv
src/report_ctrl.sv
src/uart_tx.sv
src/eye_tracker_top.sv
dv/eye_tracker_tb.sv

// ==== Makefile ====
SIM        := verilator
TOP        := eye_tracker_tb
RTL_TOP    := eye_tracker_top
FILELIST   := filelist.f
SIM_FLAGS  := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
